/* bench/rv_ctrl_tb.sv */
module rv_ctrl_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int retire_timeout = 20;
   localparam rv_ctrl_pkg::inst_t nop = 32'h00000013;   // addi x0, x0, 0

   logic clk = 1'b0;
   logic reset;
   rv_ctrl_pkg::inst_t inst_dx;
   logic cmp_true;
   logic imem_wait;
   logic dmem_wait;
   logic dmem_badmem_e;
   rv_ctrl_pkg::pc_src_t pc_src_sel;
   rv_ctrl_pkg::imm_type_t imm_type;
   rv_ctrl_pkg::src_a_sel_t src_a_sel;
   rv_ctrl_pkg::src_b_sel_t src_b_sel;
   rv_ctrl_pkg::alu_op_t alu_op;
   logic bypass_rs1;
   logic bypass_rs2;
   logic dmem_en;
   logic dmem_wen;
   logic [2:0] dmem_size;
   logic [2:0] dmem_type;
   logic wr_reg_wb;
   rv_ctrl_pkg::reg_addr_t reg_to_wr_wb;
   rv_ctrl_pkg::wb_src_t wb_src_sel_wb;
   logic stall_if;
   logic kill_if;
   logic stall_dx;
   logic kill_dx;
   logic stall_wb;
   logic kill_wb;
   logic exception_wb;
   rv_ctrl_pkg::ecode_t exception_code_wb;
   logic retire_wb;

   int errors = 0;
   int checks = 0;
   int seed = 32'h43d;

   rv_ctrl rv_ctrl_inst (.*);

   always #20 clk = ~clk;

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string msg);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail %0t: %s, got %0h expected %0h", $time, msg, actual, expected);
      end
   endtask

   // drive on the falling edge, leave a little settle time before checks
   task automatic drive_cycle(input rv_ctrl_pkg::inst_t inst, input logic cmp,
                              input logic mwait, input logic bad);
      @(negedge clk);
      inst_dx = inst;
      cmp_true = cmp;
      dmem_wait = mwait;
      dmem_badmem_e = bad;
      #1;
   endtask

   task automatic issue(input rv_ctrl_pkg::inst_t inst);
      drive_cycle(inst, 1'b0, 1'b0, 1'b0);
   endtask

   function automatic rv_ctrl_pkg::reg_addr_t rand_reg();
      return rv_ctrl_pkg::reg_addr_t'(1 + ($urandom % 31));
   endfunction

   function automatic rv_ctrl_pkg::inst_t r_type(logic [6:0] f7, logic [4:0] rs2,
         logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic rv_ctrl_pkg::inst_t i_type(logic [11:0] imm, logic [4:0] rs1,
         logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   // branches share the store field layout
   function automatic rv_ctrl_pkg::inst_t s_type(logic [11:0] imm, logic [4:0] rs2,
         logic [4:0] rs1, logic [2:0] f3, logic [6:0] opc);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
   endfunction

   function automatic rv_ctrl_pkg::alu_op_t expected_alu_op(logic [6:0] opc,
         logic [2:0] f3, logic alt);
      if (opc == rv_ctrl_pkg::opc_branch) begin
         case (f3)
            3'd0: return rv_ctrl_pkg::alu_seq;
            3'd1: return rv_ctrl_pkg::alu_sne;
            3'd4: return rv_ctrl_pkg::alu_slt;
            3'd5: return rv_ctrl_pkg::alu_sge;
            3'd6: return rv_ctrl_pkg::alu_sltu;
            3'd7: return rv_ctrl_pkg::alu_sgeu;
            default: return rv_ctrl_pkg::alu_add;
         endcase
      end
      case (f3)
         3'd0: return (opc == rv_ctrl_pkg::opc_op && alt) ? rv_ctrl_pkg::alu_sub
                                                          : rv_ctrl_pkg::alu_add;
         3'd1: return rv_ctrl_pkg::alu_sll;
         3'd2: return rv_ctrl_pkg::alu_slt;
         3'd3: return rv_ctrl_pkg::alu_sltu;
         3'd4: return rv_ctrl_pkg::alu_xor;
         3'd5: return alt ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
         3'd6: return rv_ctrl_pkg::alu_or;
         default: return rv_ctrl_pkg::alu_and;
      endcase
   endfunction

   task automatic reset_outputs();
      check(kill_if, 1'b1, "kill_if after reset");
      check(pc_src_sel, rv_ctrl_pkg::pc_replay, "pc_src_sel after reset");
      check(retire_wb, 1'b0, "retire_wb after reset");
      check(wr_reg_wb, 1'b0, "wr_reg_wb after reset");
      check(exception_wb, 1'b0, "exception_wb after reset");
      check(stall_wb, 1'b0, "stall_wb after reset");
   endtask

   task automatic arith_decode();
      logic [6:0] opc;
      rv_ctrl_pkg::reg_addr_t rd;
      for (int k = 0; k < 2; k++) begin
         opc = k ? rv_ctrl_pkg::opc_op : rv_ctrl_pkg::opc_op_imm;
         for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
               rd = rand_reg();
               issue(r_type(alt ? 7'h20 : 7'h00, 5'($urandom), 5'($urandom), 3'(f3), rd, opc));
               check(alu_op, expected_alu_op(opc, 3'(f3), alt[0]),
                     $sformatf("alu_op opc %0h f3 %0d alt %0d", opc, f3, alt));
               check(src_a_sel, rv_ctrl_pkg::src_a_rs1, "src_a_sel arith");
               check(src_b_sel, k ? rv_ctrl_pkg::src_b_rs2 : rv_ctrl_pkg::src_b_imm,
                     "src_b_sel arith");
               check(imm_type, rv_ctrl_pkg::imm_i, "imm_type arith");
               issue(nop);
               check(wr_reg_wb, 1'b1, "wr_reg_wb arith");
               check(reg_to_wr_wb, rd, "reg_to_wr_wb arith");
               check(wb_src_sel_wb, rv_ctrl_pkg::wb_src_alu, "wb_src_sel_wb arith");
               check(retire_wb, 1'b1, "retire_wb arith");
            end
         end
      end
      rd = rand_reg();
      issue({20'($urandom), rd, rv_ctrl_pkg::opc_auipc});
      check(src_a_sel, rv_ctrl_pkg::src_a_pc, "src_a_sel auipc");
      check(src_b_sel, rv_ctrl_pkg::src_b_imm, "src_b_sel auipc");
      check(imm_type, rv_ctrl_pkg::imm_u, "imm_type auipc");
      issue({20'($urandom), rd, rv_ctrl_pkg::opc_lui});
      check(src_a_sel, rv_ctrl_pkg::src_a_zero, "src_a_sel lui");
      check(imm_type, rv_ctrl_pkg::imm_u, "imm_type lui");
      issue(nop);
      check(wr_reg_wb, 1'b1, "wr_reg_wb lui");
      check(reg_to_wr_wb, rd, "reg_to_wr_wb lui");
      check(retire_wb, 1'b1, "retire_wb lui");
   endtask

   task automatic expect_exception(input rv_ctrl_pkg::inst_t inst,
                                   input rv_ctrl_pkg::ecode_t code, input string msg);
      issue(inst);
      issue(nop);
      check(exception_wb, 1'b1, {msg, " exception_wb"});
      check(exception_code_wb, code, {msg, " code"});
      check(pc_src_sel, rv_ctrl_pkg::pc_handler, {msg, " pc_src_sel"});
      check(retire_wb, 1'b0, {msg, " retire_wb"});
      check(wr_reg_wb, 1'b0, {msg, " wr_reg_wb"});
      check(kill_dx, 1'b1, {msg, " kill_dx"});
      issue(nop);
   endtask

   task automatic control_flow();
      logic [2:0] f3_list[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      rv_ctrl_pkg::inst_t inst;
      foreach (f3_list[i]) begin
         inst = s_type(12'($urandom), rand_reg(), rand_reg(), f3_list[i],
                       rv_ctrl_pkg::opc_branch);
         drive_cycle(inst, 1'b1, 1'b0, 1'b0);
         check(pc_src_sel, rv_ctrl_pkg::pc_branch_target, "taken branch pc_src_sel");
         check(kill_if, 1'b1, "taken branch kill_if");
         check(alu_op, expected_alu_op(rv_ctrl_pkg::opc_branch, f3_list[i], 1'b0),
               "branch alu_op");
         check(src_b_sel, rv_ctrl_pkg::src_b_rs2, "branch src_b_sel");
         issue(inst);   // not taken
         check(pc_src_sel, rv_ctrl_pkg::pc_plus_four, "not taken branch pc_src_sel");
         check(kill_if, 1'b0, "not taken branch kill_if");
      end
      issue({20'($urandom), rand_reg(), rv_ctrl_pkg::opc_jal});
      check(pc_src_sel, rv_ctrl_pkg::pc_jal_target, "jal pc_src_sel");
      check(src_a_sel, rv_ctrl_pkg::src_a_pc, "jal src_a_sel");
      check(src_b_sel, rv_ctrl_pkg::src_b_four, "jal src_b_sel");
      issue(i_type(12'($urandom), rand_reg(), 3'd0, rand_reg(), rv_ctrl_pkg::opc_jalr));
      check(pc_src_sel, rv_ctrl_pkg::pc_jalr_target, "jalr pc_src_sel");
      check(src_a_sel, rv_ctrl_pkg::src_a_pc, "jalr src_a_sel");
      check(src_b_sel, rv_ctrl_pkg::src_b_four, "jalr src_b_sel");
      issue(nop);
      check(wr_reg_wb, 1'b1, "jalr link write");
      expect_exception(s_type(12'($urandom), rand_reg(), rand_reg(), 3'd2,
                       rv_ctrl_pkg::opc_branch), rv_ctrl_pkg::ecode_illegal_inst,
                       "branch funct3 2");
   endtask

   task automatic exception_codes();
      expect_exception(i_type(12'h0, 5'd0, 3'd0, rand_reg(), 7'b0001111),
                       rv_ctrl_pkg::ecode_illegal_inst, "illegal opcode");
      // jalr writes a register, so the kill on the exception shows
      expect_exception(i_type(12'($urandom), rand_reg(), 3'd1, rand_reg(),
                       rv_ctrl_pkg::opc_jalr), rv_ctrl_pkg::ecode_illegal_inst,
                       "jalr funct3 1");
      expect_exception(32'h00100073, rv_ctrl_pkg::ecode_breakpoint, "ebreak");
      expect_exception(32'h00000073, rv_ctrl_pkg::ecode_ecall, "ecall");
   endtask

   task automatic hazard_detection();
      rv_ctrl_pkg::reg_addr_t rd;
      rv_ctrl_pkg::reg_addr_t other;
      rd = rand_reg();
      other = (rd % 31) + 1;   // nonzero and never rd
      issue(i_type(12'($urandom), rand_reg(), 3'd0, rd, rv_ctrl_pkg::opc_op_imm));
      issue(r_type(7'h00, other, rd, 3'd0, rand_reg(), rv_ctrl_pkg::opc_op));
      check(bypass_rs1, 1'b1, "bypass_rs1 on rs1 use");
      check(bypass_rs2, 1'b0, "bypass_rs2 on rs1 use");
      check(stall_dx, 1'b0, "stall_dx on rs1 bypass");
      check(kill_dx, 1'b0, "kill_dx on rs1 bypass");
      issue(i_type(12'($urandom), rand_reg(), 3'd0, rd, rv_ctrl_pkg::opc_op_imm));
      issue(r_type(7'h00, rd, other, 3'd0, rand_reg(), rv_ctrl_pkg::opc_op));
      check(bypass_rs2, 1'b1, "bypass_rs2 on rs2 use");
      check(bypass_rs1, 1'b0, "bypass_rs1 on rs2 use");
      check(stall_dx, 1'b0, "stall_dx on rs2 bypass");
      issue(i_type(12'($urandom), rand_reg(), 3'd0, 5'd0, rv_ctrl_pkg::opc_op_imm));
      issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, rand_reg(), rv_ctrl_pkg::opc_op));
      check(bypass_rs1, 1'b0, "x0 bypass_rs1");
      check(bypass_rs2, 1'b0, "x0 bypass_rs2");
      // load then use stalls only while the load sits in WB
      issue(i_type(12'($urandom), rand_reg(), 3'd2, rd, rv_ctrl_pkg::opc_load));
      issue(r_type(7'h00, other, rd, 3'd0, rand_reg(), rv_ctrl_pkg::opc_op));
      check(stall_dx, 1'b1, "load use stall_dx");
      check(kill_dx, 1'b1, "load use kill_dx");
      check(stall_if, 1'b1, "load use stall_if");
      check(bypass_rs1, 1'b0, "load use bypass_rs1");
      issue(r_type(7'h00, other, rd, 3'd0, rand_reg(), rv_ctrl_pkg::opc_op));
      check(stall_dx, 1'b0, "stall_dx after load left WB");
      issue(nop);
   endtask

   task automatic data_memory();
      rv_ctrl_pkg::reg_addr_t rd;
      rv_ctrl_pkg::inst_t user;
      int cycles;
      rd = rand_reg();
      user = r_type(7'h00, 5'd0, rd, 3'd0, rand_reg(), rv_ctrl_pkg::opc_op);
      issue(i_type(12'($urandom), rand_reg(), 3'd2, rd, rv_ctrl_pkg::opc_load));
      drive_cycle(user, 1'b0, 1'b1, 1'b0);
      repeat (3) begin
         check(stall_wb, 1'b1, "stall_wb during dmem_wait");
         check(kill_wb, 1'b1, "kill_wb during dmem_wait");
         check(stall_dx, 1'b1, "stall_dx while load held");
         check(stall_if, 1'b1, "stall_if while load held");
         check(retire_wb, 1'b0, "retire_wb during dmem_wait");
         drive_cycle(user, 1'b0, 1'b1, 1'b0);
      end
      issue(user);
      cycles = 0;
      while (retire_wb !== 1'b1 && cycles < retire_timeout) begin
         issue(user);
         cycles++;
      end
      if (retire_wb !== 1'b1) begin
         errors++;
         $display("load never retired after dmem_wait dropped, gave up at %0t", $time);
      end else begin
         check(reg_to_wr_wb, rd, "load destination on retire");
         check(wr_reg_wb, 1'b1, "load write on retire");
         check(wb_src_sel_wb, rv_ctrl_pkg::wb_src_mem, "load wb_src_sel_wb");
      end
      issue(nop);
      issue(i_type(12'($urandom), rand_reg(), 3'd5, rd, rv_ctrl_pkg::opc_load));
      check(dmem_en, 1'b1, "load dmem_en");
      check(dmem_wen, 1'b0, "load dmem_wen");
      check(dmem_size, 3'd1, "halfword load dmem_size");
      check(dmem_type, 3'd5, "unsigned halfword load dmem_type");
      drive_cycle(nop, 1'b0, 1'b0, 1'b1);
      check(exception_wb, 1'b1, "misaligned load exception_wb");
      check(exception_code_wb, rv_ctrl_pkg::ecode_load_misaligned, "misaligned load code");
      check(wr_reg_wb, 1'b0, "misaligned load wr_reg_wb");
      issue(s_type(12'($urandom), rand_reg(), rand_reg(), 3'd2, rv_ctrl_pkg::opc_store));
      check(dmem_en, 1'b1, "store dmem_en");
      check(dmem_wen, 1'b1, "store dmem_wen");
      check(dmem_size, 3'd2, "word store dmem_size");
      drive_cycle(nop, 1'b0, 1'b0, 1'b1);
      check(exception_wb, 1'b1, "misaligned store exception_wb");
      check(exception_code_wb, rv_ctrl_pkg::ecode_store_misaligned, "misaligned store code");
      issue(nop);
   endtask

   initial begin
      void'($urandom(seed));
      reset = 1'b1;
      inst_dx = nop;
      cmp_true = 1'b0;
      imem_wait = 1'b0;
      dmem_wait = 1'b0;
      dmem_badmem_e = 1'b0;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      #1;
      reset_outputs();
      arith_decode();
      control_flow();
      exception_codes();
      hazard_detection();
      data_memory();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* rv_ctrl.f */
source/rv_ctrl_pkg.sv
source/alu_op_decode.sv
source/inst_decoder.sv
source/hazard_unit.sv
source/pipeline_ctrl.sv
source/rv_ctrl.sv
bench/rv_ctrl_tb.sv

/* source/alu_op_decode.sv */
module alu_op_decode (
   input  logic [6:0]           opcode,
   input  logic [2:0]           funct3,
   input  logic                 alt,
   output rv_ctrl_pkg::alu_op_t alu_op
);

   always_comb begin
      alu_op = rv_ctrl_pkg::alu_add;
      if (opcode == rv_ctrl_pkg::opc_branch) begin
         case (funct3)
            rv_ctrl_pkg::f3_beq: alu_op = rv_ctrl_pkg::alu_seq;
            rv_ctrl_pkg::f3_bne: alu_op = rv_ctrl_pkg::alu_sne;
            rv_ctrl_pkg::f3_blt: alu_op = rv_ctrl_pkg::alu_slt;
            rv_ctrl_pkg::f3_bge: alu_op = rv_ctrl_pkg::alu_sge;
            rv_ctrl_pkg::f3_bltu: alu_op = rv_ctrl_pkg::alu_sltu;
            rv_ctrl_pkg::f3_bgeu: alu_op = rv_ctrl_pkg::alu_sgeu;
            default: alu_op = rv_ctrl_pkg::alu_add;   // flagged illegal in decoder
         endcase
      end else if (opcode == rv_ctrl_pkg::opc_op || opcode == rv_ctrl_pkg::opc_op_imm) begin
         case (funct3)
            rv_ctrl_pkg::f3_add_sub: begin
               // addi has no subtract form
               if (opcode == rv_ctrl_pkg::opc_op && alt)
                  alu_op = rv_ctrl_pkg::alu_sub;
            end
            rv_ctrl_pkg::f3_sll: alu_op = rv_ctrl_pkg::alu_sll;
            rv_ctrl_pkg::f3_slt: alu_op = rv_ctrl_pkg::alu_slt;
            rv_ctrl_pkg::f3_sltu: alu_op = rv_ctrl_pkg::alu_sltu;
            rv_ctrl_pkg::f3_xor: alu_op = rv_ctrl_pkg::alu_xor;
            rv_ctrl_pkg::f3_srl_sra: alu_op = alt ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
            rv_ctrl_pkg::f3_or: alu_op = rv_ctrl_pkg::alu_or;
            rv_ctrl_pkg::f3_and: alu_op = rv_ctrl_pkg::alu_and;
            default: alu_op = rv_ctrl_pkg::alu_add;
         endcase
      end
   end

endmodule

/* source/hazard_unit.sv */
module hazard_unit (
   input  rv_ctrl_pkg::inst_t     inst_dx,
   input  logic                   uses_rs1,
   input  logic                   uses_rs2,
   input  logic                   wr_reg_wb,
   input  rv_ctrl_pkg::reg_addr_t reg_to_wr_wb,
   input  logic                   load_in_wb,
   output logic                   bypass_rs1,
   output logic                   bypass_rs2,
   output logic                   load_use
);

   rv_ctrl_pkg::reg_addr_t rs1_addr;
   rv_ctrl_pkg::reg_addr_t rs2_addr;
   logic                   raw_rs1;
   logic                   raw_rs2;

   assign rs1_addr = inst_dx[19:15];
   assign rs2_addr = inst_dx[24:20];

   // x0 is never a real dependency
   assign raw_rs1 = uses_rs1 && wr_reg_wb && (rs1_addr == reg_to_wr_wb) && (rs1_addr != '0);
   assign raw_rs2 = uses_rs2 && wr_reg_wb && (rs2_addr == reg_to_wr_wb) && (rs2_addr != '0);

   assign bypass_rs1 = raw_rs1 && !load_in_wb;
   assign bypass_rs2 = raw_rs2 && !load_in_wb;
   assign load_use = load_in_wb && (raw_rs1 || raw_rs2);   // data not back until end of WB

endmodule

/* source/inst_decoder.sv */
module inst_decoder (
   input  rv_ctrl_pkg::inst_t       inst_dx,
   input  logic                     cmp_true,
   output rv_ctrl_pkg::imm_type_t   imm_type,
   output rv_ctrl_pkg::src_a_sel_t  src_a_sel,
   output rv_ctrl_pkg::src_b_sel_t  src_b_sel,
   output rv_ctrl_pkg::alu_op_t     alu_op,
   output logic                     uses_rs1,
   output logic                     uses_rs2,
   output logic                     branch_raw,
   output logic                     jal_raw,
   output logic                     jalr_raw,
   output logic                     dmem_en_raw,
   output logic                     dmem_wen_raw,
   output logic                     wr_reg_raw,
   output rv_ctrl_pkg::wb_src_t     wb_src_sel_dx,
   output logic [2:0]               dmem_size,
   output logic [2:0]               dmem_type,
   output logic                     new_ex_dx,
   output rv_ctrl_pkg::ecode_t      ex_code_dx
);

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic [11:0] funct12;
   logic        priv_fields_zero;
   logic        illegal;
   logic        ebreak;
   logic        ecall;

   assign opcode = inst_dx[6:0];
   assign funct3 = inst_dx[14:12];
   assign funct7 = inst_dx[31:25];
   assign funct12 = inst_dx[31:20];
   assign priv_fields_zero = (inst_dx[19:7] == '0);   // rs1, funct3 and rd

   assign dmem_size = {1'b0, funct3[1:0]};
   assign dmem_type = funct3;

   alu_op_decode alu_op_decode_inst (
      .opcode (opcode),
      .funct3 (funct3),
      .alt    (funct7[rv_ctrl_pkg::funct7_alt_bit]),
      .alu_op (alu_op)
   );

   always_comb begin
      illegal = 1'b0;
      ebreak = 1'b0;
      ecall = 1'b0;
      branch_raw = 1'b0;
      jal_raw = 1'b0;
      jalr_raw = 1'b0;
      uses_rs1 = 1'b1;
      uses_rs2 = 1'b0;
      imm_type = rv_ctrl_pkg::imm_i;
      src_a_sel = rv_ctrl_pkg::src_a_rs1;
      src_b_sel = rv_ctrl_pkg::src_b_imm;
      dmem_en_raw = 1'b0;
      dmem_wen_raw = 1'b0;
      wr_reg_raw = 1'b0;
      wb_src_sel_dx = rv_ctrl_pkg::wb_src_alu;
      case (opcode)
         rv_ctrl_pkg::opc_load: begin
            dmem_en_raw = 1'b1;
            wr_reg_raw = 1'b1;
            wb_src_sel_dx = rv_ctrl_pkg::wb_src_mem;
         end
         rv_ctrl_pkg::opc_store: begin
            uses_rs2 = 1'b1;
            imm_type = rv_ctrl_pkg::imm_s;
            dmem_en_raw = 1'b1;
            dmem_wen_raw = 1'b1;
         end
         rv_ctrl_pkg::opc_branch: begin
            uses_rs2 = 1'b1;
            src_b_sel = rv_ctrl_pkg::src_b_rs2;
            branch_raw = cmp_true;
            illegal = (funct3[2:1] == 2'b01);   // funct3 2 and 3 unused
         end
         rv_ctrl_pkg::opc_jal: begin
            jal_raw = 1'b1;
            uses_rs1 = 1'b0;
            src_a_sel = rv_ctrl_pkg::src_a_pc;
            src_b_sel = rv_ctrl_pkg::src_b_four;
            wr_reg_raw = 1'b1;
         end
         rv_ctrl_pkg::opc_jalr: begin
            illegal = (funct3 != 3'd0);
            jalr_raw = 1'b1;
            src_a_sel = rv_ctrl_pkg::src_a_pc;   // link value pc + 4
            src_b_sel = rv_ctrl_pkg::src_b_four;
            wr_reg_raw = 1'b1;
         end
         rv_ctrl_pkg::opc_op_imm: wr_reg_raw = 1'b1;
         rv_ctrl_pkg::opc_op: begin
            uses_rs2 = 1'b1;
            src_b_sel = rv_ctrl_pkg::src_b_rs2;
            wr_reg_raw = 1'b1;
         end
         rv_ctrl_pkg::opc_system: begin
            if (priv_fields_zero && funct12 == rv_ctrl_pkg::funct12_ecall)
               ecall = 1'b1;
            else if (priv_fields_zero && funct12 == rv_ctrl_pkg::funct12_ebreak)
               ebreak = 1'b1;
            else
               illegal = 1'b1;
         end
         rv_ctrl_pkg::opc_auipc: begin
            uses_rs1 = 1'b0;
            src_a_sel = rv_ctrl_pkg::src_a_pc;
            imm_type = rv_ctrl_pkg::imm_u;
            wr_reg_raw = 1'b1;
         end
         rv_ctrl_pkg::opc_lui: begin
            uses_rs1 = 1'b0;
            src_a_sel = rv_ctrl_pkg::src_a_zero;
            imm_type = rv_ctrl_pkg::imm_u;
            wr_reg_raw = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
   end

   assign new_ex_dx = illegal || ebreak || ecall;
   assign ex_code_dx = illegal ? rv_ctrl_pkg::ecode_illegal_inst :
                       ebreak  ? rv_ctrl_pkg::ecode_breakpoint :
                                 rv_ctrl_pkg::ecode_ecall;

   // a legal branch always gets a compare operation
   always_comb begin
      if (opcode == rv_ctrl_pkg::opc_branch && !illegal)
         branch_compares: assert final (alu_op inside {rv_ctrl_pkg::alu_seq,
            rv_ctrl_pkg::alu_sne, rv_ctrl_pkg::alu_slt, rv_ctrl_pkg::alu_sge,
            rv_ctrl_pkg::alu_sltu, rv_ctrl_pkg::alu_sgeu});
   end

endmodule

/* source/pipeline_ctrl.sv */
module pipeline_ctrl (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   imem_wait,
   input  logic                   dmem_wait,
   input  logic                   dmem_badmem_e,
   input  logic                   branch_raw,
   input  logic                   jal_raw,
   input  logic                   jalr_raw,
   input  logic                   dmem_en_raw,
   input  logic                   dmem_wen_raw,
   input  logic                   wr_reg_raw,
   input  rv_ctrl_pkg::wb_src_t   wb_src_sel_dx,
   input  rv_ctrl_pkg::reg_addr_t reg_to_wr_dx,
   input  logic                   new_ex_dx,
   input  rv_ctrl_pkg::ecode_t    ex_code_dx,
   input  logic                   load_use,
   output rv_ctrl_pkg::pc_src_t   pc_src_sel,
   output logic                   dmem_en,
   output logic                   dmem_wen,
   output logic                   stall_if,
   output logic                   kill_if,
   output logic                   stall_dx,
   output logic                   kill_dx,
   output logic                   stall_wb,
   output logic                   kill_wb,
   output logic                   exception_wb,
   output rv_ctrl_pkg::ecode_t    exception_code_wb,
   output logic                   wr_reg_wb,
   output rv_ctrl_pkg::reg_addr_t reg_to_wr_wb,
   output rv_ctrl_pkg::wb_src_t   wb_src_sel_wb,
   output logic                   load_in_wb,
   output logic                   retire_wb
);

   logic                replay_if;
   logic                branch_taken;
   logic                jal;
   logic                jalr;
   logic                redirect;
   logic                ex_dx;
   logic                wr_reg_dx;
   logic                prev_killed_wb;
   logic                had_ex_wb;
   logic                wr_reg_unkilled_wb;
   logic                store_in_wb;
   logic                dmem_en_wb;
   rv_ctrl_pkg::ecode_t prev_ex_code_wb;
   logic                dmem_access_ex;

   always_ff @(posedge clk) begin
      if (reset)
         replay_if <= 1'b1;
      else
         replay_if <= redirect && imem_wait;   // target fetch lost, go again
   end

   assign stall_if = ((imem_wait && !redirect) || stall_dx) && !exception_wb;
   assign kill_if = stall_if || ex_dx || exception_wb || redirect || replay_if;

   assign stall_dx = stall_wb || load_use;
   assign ex_dx = new_ex_dx && !stall_dx;
   assign kill_dx = stall_dx || ex_dx || exception_wb;

   assign branch_taken = branch_raw && !kill_dx;
   assign jal = jal_raw && !kill_dx;
   assign jalr = jalr_raw && !kill_dx;
   assign dmem_en = dmem_en_raw && !kill_dx;
   assign dmem_wen = dmem_wen_raw && !kill_dx;
   assign wr_reg_dx = wr_reg_raw && !kill_dx;
   assign redirect = branch_taken || jal || jalr;

   always_comb begin
      if (exception_wb)
         pc_src_sel = rv_ctrl_pkg::pc_handler;
      else if (replay_if || (stall_if && !imem_wait))
         pc_src_sel = rv_ctrl_pkg::pc_replay;
      else if (branch_taken)
         pc_src_sel = rv_ctrl_pkg::pc_branch_target;
      else if (jal)
         pc_src_sel = rv_ctrl_pkg::pc_jal_target;
      else if (jalr)
         pc_src_sel = rv_ctrl_pkg::pc_jalr_target;
      else
         pc_src_sel = rv_ctrl_pkg::pc_plus_four;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         prev_killed_wb <= 1'b1;   // nothing retires straight out of reset
         had_ex_wb <= 1'b0;
         wr_reg_unkilled_wb <= 1'b0;
         store_in_wb <= 1'b0;
         dmem_en_wb <= 1'b0;
      end else if (!stall_wb) begin
         prev_killed_wb <= kill_dx;
         had_ex_wb <= ex_dx;
         wr_reg_unkilled_wb <= wr_reg_dx;
         store_in_wb <= dmem_wen;
         dmem_en_wb <= dmem_en;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_wb) begin
         prev_ex_code_wb <= ex_code_dx;
         reg_to_wr_wb <= reg_to_wr_dx;
         wb_src_sel_wb <= wb_src_sel_dx;
      end
   end

   assign stall_wb = dmem_wait && dmem_en_wb;
   assign dmem_access_ex = dmem_badmem_e && dmem_en_wb && !stall_wb;
   assign exception_wb = had_ex_wb || dmem_access_ex;
   assign kill_wb = stall_wb || exception_wb;

   // an earlier DX cause wins over the memory fault
   assign exception_code_wb = had_ex_wb   ? prev_ex_code_wb :
                              store_in_wb ? rv_ctrl_pkg::ecode_store_misaligned :
                                            rv_ctrl_pkg::ecode_load_misaligned;

   assign wr_reg_wb = wr_reg_unkilled_wb && !kill_wb;
   assign load_in_wb = dmem_en_wb && !store_in_wb;
   assign retire_wb = !(kill_wb || prev_killed_wb);

   // a stalled WB keeps what it holds
   stall_holds_wb: assert property (@(posedge clk) disable iff (reset)
      stall_wb |=> $stable({wr_reg_unkilled_wb, reg_to_wr_wb, dmem_en_wb, store_in_wb}));
   dx_ex_reaches_wb: assert property (@(posedge clk) disable iff (reset)
      ex_dx |=> exception_wb && exception_code_wb == $past(ex_code_dx));

endmodule

/* source/rv_ctrl.sv */
module rv_ctrl (
   input  logic                    clk,
   input  logic                    reset,
   input  rv_ctrl_pkg::inst_t      inst_dx,
   input  logic                    cmp_true,
   input  logic                    imem_wait,
   input  logic                    dmem_wait,
   input  logic                    dmem_badmem_e,
   output rv_ctrl_pkg::pc_src_t    pc_src_sel,
   output rv_ctrl_pkg::imm_type_t  imm_type,
   output rv_ctrl_pkg::src_a_sel_t src_a_sel,
   output rv_ctrl_pkg::src_b_sel_t src_b_sel,
   output rv_ctrl_pkg::alu_op_t    alu_op,
   output logic                    bypass_rs1,
   output logic                    bypass_rs2,
   output logic                    dmem_en,
   output logic                    dmem_wen,
   output logic [2:0]              dmem_size,
   output logic [2:0]              dmem_type,
   output logic                    wr_reg_wb,
   output rv_ctrl_pkg::reg_addr_t  reg_to_wr_wb,
   output rv_ctrl_pkg::wb_src_t    wb_src_sel_wb,
   output logic                    stall_if,
   output logic                    kill_if,
   output logic                    stall_dx,
   output logic                    kill_dx,
   output logic                    stall_wb,
   output logic                    kill_wb,
   output logic                    exception_wb,
   output rv_ctrl_pkg::ecode_t     exception_code_wb,
   output logic                    retire_wb
);

   logic                 uses_rs1;
   logic                 uses_rs2;
   logic                 branch_raw;
   logic                 jal_raw;
   logic                 jalr_raw;
   logic                 dmem_en_raw;
   logic                 dmem_wen_raw;
   logic                 wr_reg_raw;
   rv_ctrl_pkg::wb_src_t wb_src_sel_dx;
   logic                 new_ex_dx;
   rv_ctrl_pkg::ecode_t  ex_code_dx;
   logic                 load_use;
   logic                 load_in_wb;

   inst_decoder inst_decoder_inst (
      .inst_dx, .cmp_true, .imm_type, .src_a_sel, .src_b_sel, .alu_op,
      .uses_rs1, .uses_rs2, .branch_raw, .jal_raw, .jalr_raw,
      .dmem_en_raw, .dmem_wen_raw, .wr_reg_raw, .wb_src_sel_dx,
      .dmem_size, .dmem_type, .new_ex_dx, .ex_code_dx
   );

   hazard_unit hazard_unit_inst (
      .inst_dx, .uses_rs1, .uses_rs2, .wr_reg_wb, .reg_to_wr_wb, .load_in_wb,
      .bypass_rs1, .bypass_rs2, .load_use
   );

   pipeline_ctrl pipeline_ctrl_inst (
      .clk, .reset, .imem_wait, .dmem_wait, .dmem_badmem_e,
      .branch_raw, .jal_raw, .jalr_raw, .dmem_en_raw, .dmem_wen_raw, .wr_reg_raw,
      .wb_src_sel_dx, .reg_to_wr_dx (inst_dx[11:7]), .new_ex_dx, .ex_code_dx, .load_use,
      .pc_src_sel, .dmem_en, .dmem_wen, .stall_if, .kill_if, .stall_dx, .kill_dx,
      .stall_wb, .kill_wb, .exception_wb, .exception_code_wb, .wr_reg_wb,
      .reg_to_wr_wb, .wb_src_sel_wb, .load_in_wb, .retire_wb
   );

endmodule

/* source/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

   localparam int inst_width = 32;
   localparam int reg_addr_width = 5;

   typedef logic [inst_width-1:0] inst_t;
   typedef logic [reg_addr_width-1:0] reg_addr_t;
   typedef logic [3:0] ecode_t;

   typedef enum logic [3:0] {
      alu_add = 4'd0, alu_sll = 4'd1, alu_xor = 4'd4, alu_srl = 4'd5,
      alu_or = 4'd6, alu_and = 4'd7, alu_seq = 4'd8, alu_sne = 4'd9,
      alu_sub = 4'd10, alu_sra = 4'd11, alu_slt = 4'd12, alu_sge = 4'd13,
      alu_sltu = 4'd14, alu_sgeu = 4'd15
   } alu_op_t;

   typedef enum logic [2:0] {
      pc_plus_four = 3'd0, pc_branch_target = 3'd1, pc_jal_target = 3'd2,
      pc_jalr_target = 3'd3, pc_replay = 3'd4, pc_handler = 3'd5
   } pc_src_t;

   typedef enum logic [1:0] {imm_i = 2'd0, imm_s = 2'd1, imm_u = 2'd2} imm_type_t;
   typedef enum logic [1:0] {src_a_rs1 = 2'd0, src_a_pc = 2'd1, src_a_zero = 2'd2} src_a_sel_t;
   typedef enum logic [1:0] {src_b_rs2 = 2'd0, src_b_imm = 2'd1, src_b_four = 2'd2} src_b_sel_t;
   typedef enum logic {wb_src_alu = 1'b0, wb_src_mem = 1'b1} wb_src_t;

   localparam logic [6:0] opc_load = 7'b0000011;
   localparam logic [6:0] opc_store = 7'b0100011;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jal = 7'b1101111;
   localparam logic [6:0] opc_jalr = 7'b1100111;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_op = 7'b0110011;
   localparam logic [6:0] opc_system = 7'b1110011;
   localparam logic [6:0] opc_auipc = 7'b0010111;
   localparam logic [6:0] opc_lui = 7'b0110111;

   // branch compares
   localparam logic [2:0] f3_beq = 3'd0;
   localparam logic [2:0] f3_bne = 3'd1;
   localparam logic [2:0] f3_blt = 3'd4;
   localparam logic [2:0] f3_bge = 3'd5;
   localparam logic [2:0] f3_bltu = 3'd6;
   localparam logic [2:0] f3_bgeu = 3'd7;

   localparam logic [2:0] f3_add_sub = 3'd0;
   localparam logic [2:0] f3_sll = 3'd1;
   localparam logic [2:0] f3_slt = 3'd2;
   localparam logic [2:0] f3_sltu = 3'd3;
   localparam logic [2:0] f3_xor = 3'd4;
   localparam logic [2:0] f3_srl_sra = 3'd5;
   localparam logic [2:0] f3_or = 3'd6;
   localparam logic [2:0] f3_and = 3'd7;

   localparam logic [11:0] funct12_ecall = 12'h000;
   localparam logic [11:0] funct12_ebreak = 12'h001;
   localparam int funct7_alt_bit = 5;   // inst bit 30

   localparam ecode_t ecode_illegal_inst = 4'd2;
   localparam ecode_t ecode_breakpoint = 4'd3;
   localparam ecode_t ecode_load_misaligned = 4'd4;
   localparam ecode_t ecode_store_misaligned = 4'd6;
   localparam ecode_t ecode_ecall = 4'd11;

endpackage
